// File: sources.f
src/dd2_map_pkg.sv
src/dd2_sdram_pkg.sv
src/rom_req_if.sv
src/prog_mapper.sv
src/rom_slot.sv
src/sdram_arbiter.sv
src/dd2_rom_top.sv
test/tb_clock.sv
test/dd2_rom_assertions.sv
test/dd2_rom_tb.sv

// File: test/dd2_rom_tb.sv
// SDRAM model answers one request at a time, checking lives in the bound assertion module
`timescale 1ns/10ps

module dd2_rom_tb
    import dd2_map_pkg::*;
    import dd2_sdram_pkg::*;
();

    logic        clk, arst_n;
    logic        downloading, dwnld_busy, ioctl_wr;
    logic [21:0] ioctl_addr;
    byte_t       ioctl_data, prog_data, main_data, char_data;
    sdram_addr_t prog_addr, sdram_addr;
    logic [1:0]  prog_mask;
    logic        prog_we, prom_we, sdram_req, sdram_ack, data_rdy, refresh_en;
    sdram_line_t data_read;
    logic        main_cs, main_ok, char_cs, char_ok, obj_cs, obj_ok;
    logic [17:0] main_addr;
    logic [15:0] char_addr;
    logic [18:0] obj_addr;
    word_t       obj_data;
    int          seed = 4;
    logic [21:0] regions [10];

    tb_clock u_clock (.clk(clk), .arst_n(arst_n));

    dd2_rom_top DUT (.*);

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped");
    endtask

    // First failing assertion ends the run
    always @(posedge clk) begin
        if (DUT.u_chk.err_cnt != 0) begin
            stop_with_failure("An assertion failed");
        end
    end

    // SDRAM controller model with random ack and read latency
    always begin
        sdram_addr_t a;
        logic        rd;
        @(posedge clk);
        if ((sdram_req || prog_we) && !sdram_ack) begin
            rd = sdram_req;
            a  = sdram_addr;
            repeat ($unsigned($random(seed)) % 4) @(posedge clk);
            sdram_ack <= 1'b1;
            @(posedge clk);
            sdram_ack <= 1'b0;
            if (rd) begin
                repeat ($unsigned($random(seed)) % 6 + 1) @(posedge clk);
                data_read <= {~a[15:0], a[15:0]};
                data_rdy  <= 1'b1;
                @(posedge clk);
                data_rdy  <= 1'b0;
            end
        end
    end

    function automatic logic client_ok(input int sel);
        return sel == 0 ? main_ok : (sel == 1 ? char_ok : obj_ok);
    endfunction

    task automatic set_cs(input int sel, input logic on, input logic [18:0] a);
        case (sel)
            0: begin
                main_cs   <= on;
                main_addr <= a[17:0];
            end
            1: begin
                char_cs   <= on;
                char_addr <= a[15:0];
            end
            default: begin
                obj_cs   <= on;
                obj_addr <= a;
            end
        endcase
    endtask

    task automatic loader_write(input logic [21:0] a, input byte_t d);
        int n;
        @(posedge clk);
        ioctl_addr <= a;
        ioctl_data <= d;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
        for (n = 0; n < 50; n++) begin
            @(posedge clk);
            if (!prog_we) break;
        end
        if (n == 50) stop_with_failure("Timeout waiting for prog_we to drop");
    endtask

    // Raise cs for each selected client and drop it as its ok arrives
    task automatic read_clients(input logic [2:0] sel, input logic [18:0] a [3]);
        int         n;
        logic [2:0] pend;
        pend = sel;
        @(posedge clk);
        for (int i = 0; i < 3; i++) begin
            if (sel[i]) begin
                set_cs(i, 1'b1, a[i]);
            end
        end
        for (n = 0; n < 300 && pend != 0; n++) begin
            @(posedge clk);
            for (int i = 0; i < 3; i++) begin
                if (pend[i] && client_ok(i)) begin
                    set_cs(i, 1'b0, a[i]);
                    pend[i] = 1'b0;
                end
            end
        end
        if (pend != 0) stop_with_failure("Timeout waiting for a client ok");
    endtask

    initial begin
        int          n;
        int          sel;
        logic [18:0] a [3];
        {downloading, ioctl_wr, sdram_ack, data_rdy} = '0;
        {main_cs, char_cs, obj_cs} = '0;
        ioctl_addr = '0;
        ioctl_data = '0;
        data_read  = '0;
        main_addr  = '0;
        char_addr  = '0;
        obj_addr   = '0;
        regions = '{BANK_ADDR, MAIN_ADDR, SND_ADDR, SUB_ADDR, ADPCM_0, ADPCM_1,
                    CHAR_ADDR, SCRZW_ADDR, OBJWZ_ADDR, PROM_ADDR};
        for (n = 0; n < 100; n++) begin
            @(posedge clk);
            if (arst_n) break;
        end
        if (n == 100) stop_with_failure("Reset never released");
        @(posedge clk);
        downloading <= 1'b1;
        a[0] = 19'h0_4321;
        set_cs(0, 1'b1, a[0]);                   // Main read waits for the download
        foreach (regions[r]) begin
            loader_write(regions[r], byte_t'($random(seed)));
            loader_write(regions[r] + 22'h1, byte_t'($random(seed)));
            loader_write(regions[r] + 22'h123, byte_t'($random(seed)));
        end
        @(posedge clk);
        downloading <= 1'b0;
        read_clients(3'b001, a);
        // Small address pool gives repeats and same line neighbours
        for (int k = 0; k < 80; k++) begin
            sel  = $unsigned($random(seed)) % 3;
            a[0] = 19'($unsigned($random(seed)) % 16);
            a[1] = a[0];
            a[2] = a[0];
            read_clients(3'b001 << sel, a);
        end
        // Fresh addresses for main and obj together
        for (int k = 0; k < 4; k++) begin
            a[0] = 19'h1000 + 19'(k * 64);
            a[1] = '0;
            a[2] = 19'h2000 + 19'(k * 64);
            repeat (3) @(posedge clk);
            read_clients(3'b101, a);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);                          // Checks of the last edge have run
        if (DUT.u_chk.err_cnt == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            stop_with_failure("Checks failed during the run");
        end
    end

endmodule

// File: test/dd2_rom_assertions.sv
// Checks assume the loader waits for prog_we to drop and clients hold cs and addr until ok
`timescale 1ns/10ps

module dd2_rom_assertions
    import dd2_map_pkg::*;
    import dd2_sdram_pkg::*;
(
    input logic        clk,
    input logic        arst_n,
    input logic        downloading,
    input logic        dwnld_busy,
    input logic [21:0] ioctl_addr,
    input byte_t       ioctl_data,
    input logic        ioctl_wr,
    input sdram_addr_t prog_addr,
    input byte_t       prog_data,
    input logic [1:0]  prog_mask,
    input logic        prog_we,
    input logic        prom_we,
    input logic        sdram_req,
    input sdram_addr_t sdram_addr,
    input logic        sdram_ack,
    input logic        refresh_en,
    input logic        main_cs,
    input logic [17:0] main_addr,
    input byte_t       main_data,
    input logic        main_ok,
    input logic        char_cs,
    input logic [15:0] char_addr,
    input byte_t       char_data,
    input logic        char_ok,
    input logic        obj_cs,
    input logic [18:0] obj_addr,
    input word_t       obj_data,
    input logic        obj_ok
);

    int          err_cnt = 0;
    logic [21:0] wr_a;           // Last loader write
    byte_t       wr_d;

    // Where a loader byte must land in SDRAM words
    function automatic sdram_addr_t exp_addr(input logic [21:0] a);
        if (a < SCRZW_ADDR) begin
            return a >> 1;
        end else if (a < OBJWZ_ADDR) begin
            return SCR_SDRAM + ((a - SCRZW_ADDR) >> 1);
        end
        return OBJ_SDRAM + ((a - OBJWZ_ADDR) >> 1);
    endfunction

    // Model line low half is the word address, byte picked by parity
    function automatic byte_t exp_byte(input sdram_addr_t off, input logic [18:0] a);
        sdram_addr_t w;
        w = off + sdram_addr_t'(a >> 1);
        return a[0] ? w[15:8] : w[7:0];
    endfunction

    always @(posedge clk) begin
        if (downloading && ioctl_wr) begin
            wr_a <= ioctl_addr;
            wr_d <= ioctl_data;
        end
    end

    a_reset: assert property (@(posedge clk) $rose(arst_n) |-> !sdram_req && !prog_we && !prom_we
        && !main_ok && !char_ok && !obj_ok && refresh_en)
        else begin
            $error("Outputs not idle after reset");
            err_cnt++;
        end

    a_busy: assert property (@(posedge clk) dwnld_busy == downloading)
        else begin
            $error("** Error %0t dwnld_busy=%b expected %b", $time, $sampled(dwnld_busy),
                   $sampled(downloading));
            err_cnt++;
        end

    a_prog_addr: assert property (@(posedge clk) disable iff (!arst_n)
        downloading && ioctl_wr && ioctl_addr < PROM_ADDR |=> prog_we && !prom_we
        && prog_addr == exp_addr(wr_a))
        else begin
            $error("** Error %0t prog_addr=%h expected %h", $time, $sampled(prog_addr),
                   exp_addr($sampled(wr_a)));
            err_cnt++;
        end

    a_prog_data: assert property (@(posedge clk) disable iff (!arst_n)
        downloading && ioctl_wr && ioctl_addr < PROM_ADDR |=> prog_data == wr_d
        && prog_mask == (wr_a[0] ? 2'b01 : 2'b10))
        else begin
            $error("** Error %0t prog_data=%h prog_mask=%b expected %h %b", $time,
                   $sampled(prog_data), $sampled(prog_mask), $sampled(wr_d),
                   ($sampled(wr_a[0]) ? 2'b01 : 2'b10));
            err_cnt++;
        end

    a_prog_hold: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we && !sdram_ack |=> prog_we)
        else begin
            $error("prog_we dropped before sdram_ack");
            err_cnt++;
        end

    a_prog_release: assert property (@(posedge clk) disable iff (!arst_n)
        prog_we && sdram_ack |=> !prog_we)
        else begin
            $error("prog_we still high after sdram_ack");
            err_cnt++;
        end

    a_prom: assert property (@(posedge clk) disable iff (!arst_n)
        downloading && ioctl_wr && ioctl_addr >= PROM_ADDR |=> prom_we && !prog_we ##1 !prom_we)
        else begin
            $error("PROM write did not give a single prom_we pulse");
            err_cnt++;
        end

    a_no_read_in_dl: assert property (@(posedge clk) disable iff (!arst_n)
        downloading |-> !sdram_req)
        else begin
            $error("sdram_req raised during download");
            err_cnt++;
        end

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr))
        else begin
            $error("SDRAM request changed before sdram_ack");
            err_cnt++;
        end

    a_main_data: assert property (@(posedge clk) disable iff (!arst_n)
        main_ok |-> main_data == exp_byte(MAIN_OFFSET, main_addr))
        else begin
            $error("** Error %0t main_data=%h expected %h", $time, $sampled(main_data),
                   exp_byte(MAIN_OFFSET, $sampled(main_addr)));
            err_cnt++;
        end

    a_char_data: assert property (@(posedge clk) disable iff (!arst_n)
        char_ok |-> char_data == exp_byte(CHAR_OFFSET, char_addr))
        else begin
            $error("** Error %0t char_data=%h expected %h", $time, $sampled(char_data),
                   exp_byte(CHAR_OFFSET, $sampled(char_addr)));
            err_cnt++;
        end

    a_obj_data: assert property (@(posedge clk) disable iff (!arst_n)
        obj_ok |-> obj_data == word_t'(OBJ_OFFSET + sdram_addr_t'(obj_addr)))
        else begin
            $error("** Error %0t obj_data=%h expected %h", $time, $sampled(obj_data),
                   word_t'(OBJ_OFFSET + sdram_addr_t'($sampled(obj_addr))));
            err_cnt++;
        end

    // Main missing with a steady address must win over obj
    a_priority: assert property (@(posedge clk) disable iff (!arst_n || downloading)
        $rose(sdram_req) && main_cs && $past(main_cs) && $past(main_cs, 2) && obj_cs
        && !main_ok && !$past(main_ok) && main_addr == $past(main_addr)
        && $past(main_addr) == $past(main_addr, 2)
        |-> sdram_addr == MAIN_OFFSET + sdram_addr_t'(main_addr >> 1))
        else begin
            $error("** Error %0t sdram_addr=%h expected %h", $time, $sampled(sdram_addr),
                   MAIN_OFFSET + sdram_addr_t'($sampled(main_addr) >> 1));
            err_cnt++;
        end

    a_no_refresh: assert property (@(posedge clk) disable iff (!arst_n)
        ((main_cs && !main_ok) || (char_cs && !char_ok) || (obj_cs && !obj_ok))[*3]
        |-> !refresh_en)
        else begin
            $error("refresh_en high while a client waits");
            err_cnt++;
        end

endmodule

bind dd2_rom_top dd2_rom_assertions u_chk (.*);

// File: test/tb_clock.sv
// Free running 40 ns clock, reset held low for the first 16 rising edges
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;                      // Released on an edge like the stimulus
    end

endmodule

// File: src/dd2_rom_top.sv
// ROM path only, clients must hold cs and addr until ok and the SDRAM controller serves one read
`timescale 1ns/10ps

module dd2_rom_top
    import dd2_map_pkg::*;
    import dd2_sdram_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    // Download
    input  logic        downloading,
    output logic        dwnld_busy,
    input  logic [21:0] ioctl_addr,
    input  byte_t       ioctl_data,
    input  logic        ioctl_wr,
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    // SDRAM controller
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_line_t data_read,
    output logic        refresh_en,
    // Main CPU program
    input  logic        main_cs,
    input  logic [17:0] main_addr,
    output byte_t       main_data,
    output logic        main_ok,
    // Character graphics
    input  logic        char_cs,
    input  logic [15:0] char_addr,
    output byte_t       char_data,
    output logic        char_ok,
    // Object graphics
    input  logic        obj_cs,
    input  logic [18:0] obj_addr,
    output word_t       obj_data,
    output logic        obj_ok
);

    rom_req_if rom_bus [SLOT_N] ();

    assign dwnld_busy = downloading;

    prog_mapper u_mapper (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_slot #(
        .payload_t (byte_t),
        .aw        (18),
        .offset    (MAIN_OFFSET)
    ) u_main_slot (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (main_cs),
        .addr   (main_addr),
        .data   (main_data),
        .ok     (main_ok),
        .bus    (rom_bus[SLOT_MAIN])
    );

    rom_slot #(
        .payload_t (byte_t),
        .aw        (16),
        .offset    (CHAR_OFFSET)
    ) u_char_slot (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (char_cs),
        .addr   (char_addr),
        .data   (char_data),
        .ok     (char_ok),
        .bus    (rom_bus[SLOT_CHAR])
    );

    // Objects read whole words
    rom_slot #(
        .payload_t (word_t),
        .aw        (19),
        .offset    (OBJ_OFFSET)
    ) u_obj_slot (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (obj_cs),
        .addr   (obj_addr),
        .data   (obj_data),
        .ok     (obj_ok),
        .bus    (rom_bus[SLOT_OBJ])
    );

    sdram_arbiter u_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .slots       (rom_bus),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .refresh_en  (refresh_en)
    );

endmodule

// File: src/sdram_arbiter.sv
// One read outstanding at a time, downloading aborts any grant and keeps sdram_req low
`timescale 1ns/10ps

module sdram_arbiter
    import dd2_sdram_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    rom_req_if.server   slots [SLOT_N],
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_line_t data_read,
    output logic        refresh_en
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_DATA
    } state_t;

    typedef logic [$clog2(SLOT_N)-1:0] slot_idx_t;

    state_t            state;
    slot_idx_t         gnt;
    slot_idx_t         pick;
    logic              any_req;
    logic [SLOT_N-1:0] req_vec;
    sdram_addr_t       addr_vec [SLOT_N];

    generate
        for (genvar i = 0; i < SLOT_N; i++) begin : g_slot
            assign req_vec[i]  = slots[i].req;
            assign addr_vec[i] = slots[i].addr;
            // Only the granted slot sees the end of the read
            assign slots[i].done = (state == WAIT_DATA) && data_rdy && (gnt == slot_idx_t'(i));
            assign slots[i].data = data_read;
        end
    endgenerate

    // Fixed priority, lowest index first
    always_comb begin
        pick    = '0;
        any_req = |req_vec;
        for (int i = SLOT_N - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                pick = slot_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            gnt   <= '0;
        end else if (downloading) begin
            state <= IDLE;                           // SDRAM belongs to the loader
        end else begin
            case (state)
                IDLE: begin
                    if (any_req) begin
                        gnt   <= pick;
                        state <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (sdram_ack) begin
                        state <= WAIT_DATA;
                    end
                end
                WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && any_req) begin
            sdram_addr <= addr_vec[pick];            // Held through the ack
        end
    end

    assign sdram_req  = (state == WAIT_ACK) && !downloading;
    assign refresh_en = (state == IDLE) && !any_req;

endmodule

// File: src/rom_slot.sv
// Caches one SDRAM line, the client must hold cs and addr until ok for the request to complete
`timescale 1ns/10ps

module rom_slot
    import dd2_sdram_pkg::*;
#(
    parameter type         payload_t = byte_t,
    parameter int          aw        = 16,
    parameter sdram_addr_t offset    = '0
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          cs,
    input  logic [aw-1:0] addr,
    output payload_t      data,
    output logic          ok,
    rom_req_if.client     bus
);

    logic          cs_r;        // Captured request, frozen while waiting
    logic [aw-1:0] addr_r;
    logic          valid;
    sdram_line_t   line;
    sdram_addr_t   line_addr;
    sdram_addr_t   word_addr;
    logic          hit;
    logic          same;
    logic          req;

    generate
        if ($bits(payload_t) == 8) begin : g_byte
            // Two bytes per SDRAM word
            assign word_addr = offset + sdram_addr_t'(addr_r >> 1);
            assign data      = addr_r[0] ? line[15:8] : line[7:0];
        end else begin : g_word
            assign word_addr = offset + sdram_addr_t'(addr_r);
            assign data      = line[15:0];
        end
    endgenerate

    assign hit  = valid && (line_addr == word_addr);
    assign same = cs_r && (addr == addr_r);          // No change since capture
    assign req  = cs_r && !hit;

    assign bus.req  = req;
    assign bus.addr = word_addr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cs_r  <= 1'b0;
            valid <= 1'b0;
            ok    <= 1'b0;
        end else begin
            if (!req) begin
                cs_r <= cs;
            end
            if (bus.done) begin
                valid <= 1'b1;
            end
            // Served from the line or from the read just finished
            ok <= cs && same && (hit || bus.done);
        end
    end

    always_ff @(posedge clk) begin
        if (!req) begin
            addr_r <= addr;                          // Address stays put during a read
        end
        if (bus.done) begin
            line      <= bus.data;
            line_addr <= word_addr;
        end
    end

endmodule

// File: src/prog_mapper.sv
// Loader must not pulse ioctl_wr while prog_we is high, regions are relocated linearly
`timescale 1ns/10ps

module prog_mapper
    import dd2_map_pkg::*;
    import dd2_sdram_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic [21:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    input  logic        sdram_ack,
    output sdram_addr_t prog_addr,
    output logic [7:0]  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    output logic        prom_we
);

    logic [21:0] scr_rel;
    logic [21:0] obj_rel;
    logic [21:0] prom_rel;
    sdram_addr_t sdram_dst;
    logic        is_prom;
    logic        wr_ok;

    // Distances into each relocated region
    assign scr_rel  = ioctl_addr - SCRZW_ADDR;
    assign obj_rel  = ioctl_addr - OBJWZ_ADDR;
    assign prom_rel = ioctl_addr - PROM_ADDR;

    assign is_prom = ioctl_addr >= PROM_ADDR;
    assign wr_ok   = ioctl_wr && downloading;

    always_comb begin
        if (ioctl_addr < SCRZW_ADDR) begin
            sdram_dst = ioctl_addr >> 1;               // Same layout as the stream
        end else if (ioctl_addr < OBJWZ_ADDR) begin
            sdram_dst = SCR_SDRAM + (scr_rel >> 1);
        end else begin
            sdram_dst = OBJ_SDRAM + (obj_rel >> 1);
        end
    end

    // Write strobes
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= 1'b0;                           // Single cycle pulse
            if (sdram_ack) begin
                prog_we <= 1'b0;
            end
            if (wr_ok) begin
                prog_we <= !is_prom;
                prom_we <= is_prom;
            end
        end
    end

    // Address and data for the pending write
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;   // Masked byte is not written
            if (is_prom) begin
                prog_addr <= {{(SDRAM_AW-PROM_AW){1'b0}}, prom_rel[PROM_AW-1:0]};
            end else begin
                prog_addr <= sdram_dst;
            end
        end
    end

endmodule

// File: src/rom_req_if.sv
// Request held with a stable address until done, done is a single cycle pulse carrying the line
`timescale 1ns/10ps

interface rom_req_if
    import dd2_sdram_pkg::*;
();

    logic        req;    // Level from the slot
    sdram_addr_t addr;   // Word address of the wanted line
    logic        done;   // One cycle, read finished
    sdram_line_t data;   // Line read at addr

    // ROM slot side
    modport client (
        output req,
        output addr,
        input  done,
        input  data
    );

    // Arbiter side
    modport server (
        input  req,
        input  addr,
        output done,
        output data
    );

endinterface

// File: src/dd2_sdram_pkg.sv
// SDRAM reads return 32 bits per 16-bit word address and the slot indexes double as priority
package dd2_sdram_pkg;

    localparam int SDRAM_AW = 22;   // 16-bit word address
    localparam int SDRAM_DW = 32;   // One read burst

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [SDRAM_DW-1:0] sdram_line_t;

    // Slot payloads
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] word_t;

    // Number of ROM clients sharing the SDRAM
    localparam int SLOT_N = 3;

    // Lower index wins arbitration
    localparam int SLOT_MAIN = 0;
    localparam int SLOT_CHAR = 1;
    localparam int SLOT_OBJ  = 2;

endpackage

// File: src/dd2_map_pkg.sv
// Byte addresses of the download stream and SDRAM word bases, valid only for the DD2 ROM set order
package dd2_map_pkg;

    // Download stream layout in bytes
    localparam logic [21:0] BANK_ADDR  = 22'h00_0000;
    localparam logic [21:0] MAIN_ADDR  = 22'h02_0000;
    localparam logic [21:0] SND_ADDR   = 22'h02_8000;
    localparam logic [21:0] SUB_ADDR   = 22'h03_0000;
    localparam logic [21:0] ADPCM_0    = 22'h04_0000;
    localparam logic [21:0] ADPCM_1    = 22'h06_0000;
    localparam logic [21:0] CHAR_ADDR  = 22'h08_0000;
    localparam logic [21:0] SCRZW_ADDR = 22'h09_0000;   // Scroll planes start here
    localparam logic [21:0] OBJWZ_ADDR = 22'h0D_0000;   // Object planes start here
    localparam logic [21:0] PROM_ADDR  = 22'h19_0000;   // Priority PROM, goes to BRAM

    // Relocated graphics in 16-bit SDRAM words
    localparam logic [21:0] SCR_SDRAM  = 22'h06_0000;
    localparam logic [21:0] OBJ_SDRAM  = 22'h08_0000;

    // Word offsets added by each ROM slot
    localparam logic [21:0] MAIN_OFFSET = BANK_ADDR >> 1;
    localparam logic [21:0] CHAR_OFFSET = CHAR_ADDR >> 1;
    localparam logic [21:0] OBJ_OFFSET  = OBJ_SDRAM;

    // Priority PROM depth is 256 entries
    localparam int PROM_AW = 8;

endpackage
